// File: logic/rg_axi_pkg.sv
/*
 * AXI read-channel field types seen by the read guard.
 * Imported by every guard module that handles addresses, IDs or burst lengths.
 */

`default_nettype none

package rg_axi_pkg;

  // Read transaction ID
  typedef logic [3:0] axi_id_t;

  // Read address
  typedef logic [31:0] axi_addr_t;

  // Burst length field, beats = len + 1
  typedef logic [7:0] axi_len_t;

endpackage

`default_nettype wire

// File: logic/rg_guard_pkg.sv
/*
 * Guard-internal types: tick counts, budgets, phase and error cause encodings,
 * plus the default configuration used by the top level.
 */

`default_nettype none

package rg_guard_pkg;

  // Prescaler ticks, shared by budgets, counters and latencies
  typedef logic [11:0] tick_cnt_t;

  // Per-beat budget scaled by the beat count
  typedef logic [19:0] burst_budget_t;

  // Phase of the transaction at the head of the queue
  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_WAIT_FIRST,
    PHASE_IN_BURST
  } txn_phase_e;

  // Reason for an error report
  typedef enum logic [2:0] {
    CAUSE_NONE,
    CAUSE_AR_STALL,
    CAUSE_FIRST_LATE,
    CAUSE_BURST_LATE,
    CAUSE_UNWANTED,
    CAUSE_OVERFLOW
  } err_cause_e;

  // Default queue depth and clock cycles per tick
  localparam int unsigned DefMaxTxns      = 4;
  localparam int unsigned DefPrescalerDiv = 4;

endpackage

`default_nettype wire

// File: logic/rg_tick_timer.sv
/*
 * Prescaled time base of the read guard. Counts ticks of an address stall
 * and ticks spent in the current phase of the head transaction.
 */

`default_nettype none

module rg_tick_timer #(
  parameter int unsigned PrescalerDiv = rg_guard_pkg::DefPrescalerDiv
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ar_valid_i,
  input  logic                    ar_ready_i,
  input  logic                    phase_clr_i,
  output rg_guard_pkg::tick_cnt_t ar_stall_cnt_o,
  output rg_guard_pkg::tick_cnt_t phase_cnt_o
);
  import rg_guard_pkg::*;

  localparam int unsigned DivW = $clog2(PrescalerDiv);

  logic [DivW-1:0] div_q;
  logic            tick;
  logic            ar_stall;
  tick_cnt_t       ar_stall_cnt_q;
  tick_cnt_t       phase_cnt_q;

  // One tick in the last cycle of every divider period
  assign tick     = (div_q == DivW'(PrescalerDiv - 1));
  assign ar_stall = ar_valid_i && !ar_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q          <= '0;
      ar_stall_cnt_q <= '0;
      phase_cnt_q    <= '0;
    end else begin
      div_q <= tick ? '0 : div_q + 1'b1;

      // Stall count only lives as long as the stall itself
      if (!ar_stall) begin
        ar_stall_cnt_q <= '0;
      end else if (tick && (ar_stall_cnt_q != '1)) begin
        ar_stall_cnt_q <= ar_stall_cnt_q + 1'b1;
      end

      // Restarted on every phase entry, saturates at full scale
      if (phase_clr_i) begin
        phase_cnt_q <= '0;
      end else if (tick && (phase_cnt_q != '1)) begin
        phase_cnt_q <= phase_cnt_q + 1'b1;
      end
    end
  end

  assign ar_stall_cnt_o = ar_stall_cnt_q;
  assign phase_cnt_o    = phase_cnt_q;

endmodule

`default_nettype wire

// File: logic/rg_txn_queue.sv
/*
 * In-order queue of accepted read addresses. The oldest entry is presented
 * to the phase FSM, which pops it when its burst completes.
 */

`default_nettype none

module rg_txn_queue #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ar_valid_i,
  input  logic                  ar_ready_i,
  input  rg_axi_pkg::axi_id_t   ar_id_i,
  input  rg_axi_pkg::axi_addr_t ar_addr_i,
  input  rg_axi_pkg::axi_len_t  ar_len_i,
  input  logic                  pop_i,
  input  logic                  flush_i,
  output logic                  head_valid_o,
  output rg_axi_pkg::axi_id_t   head_id_o,
  output rg_axi_pkg::axi_addr_t head_addr_o,
  output rg_axi_pkg::axi_len_t  head_len_o,
  output logic                  overflow_o
);
  import rg_axi_pkg::*;

  localparam int unsigned PtrW = $clog2(MaxTxns);
  localparam int unsigned CntW = $clog2(MaxTxns + 1);

  axi_id_t   id_mem   [MaxTxns];
  axi_addr_t addr_mem [MaxTxns];
  axi_len_t  len_mem  [MaxTxns];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            accept;
  logic            full;
  logic            push;
  logic            pop;

  assign accept = ar_valid_i && ar_ready_i;
  assign full   = (count_q == CntW'(MaxTxns));
  assign push   = accept && !full;
  assign pop    = pop_i && (count_q != '0);

  // A read seen while full is dropped and flagged
  assign overflow_o = accept && full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(MaxTxns - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(MaxTxns - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q]   <= ar_id_i;
      addr_mem[wr_ptr_q] <= ar_addr_i;
      len_mem[wr_ptr_q]  <= ar_len_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_id_o    = id_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_len_o   = len_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: logic/rg_txn_fsm.sv
/*
 * Follows the head read through its first-data and burst phases, checks the
 * tick counts against the budgets and selects one error cause per cycle.
 */

`default_nettype none

module rg_txn_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     head_valid_i,
  input  rg_axi_pkg::axi_id_t      head_id_i,
  input  rg_axi_pkg::axi_addr_t    head_addr_i,
  input  rg_axi_pkg::axi_len_t     head_len_i,
  input  logic                     ar_valid_i,
  input  logic                     ar_ready_i,
  input  rg_axi_pkg::axi_addr_t    ar_addr_i,
  input  rg_axi_pkg::axi_id_t      ar_id_i,
  input  logic                     r_valid_i,
  input  logic                     r_ready_i,
  input  logic                     r_last_i,
  input  rg_axi_pkg::axi_id_t      r_id_i,
  input  logic                     overflow_i,
  input  rg_guard_pkg::tick_cnt_t  ar_stall_cnt_i,
  input  rg_guard_pkg::tick_cnt_t  phase_cnt_i,
  input  rg_guard_pkg::tick_cnt_t  budget_ar_i,
  input  rg_guard_pkg::tick_cnt_t  budget_first_i,
  input  rg_guard_pkg::tick_cnt_t  budget_beat_i,
  output logic                     pop_o,
  output logic                     flush_o,
  output logic                     phase_clr_o,
  output logic                     err_valid_o,
  output rg_guard_pkg::err_cause_e err_cause_o,
  output rg_axi_pkg::axi_addr_t    err_addr_o,
  output rg_axi_pkg::axi_id_t      err_id_o,
  output logic                     lat_valid_o,
  output rg_guard_pkg::tick_cnt_t  lat_first_o,
  output rg_guard_pkg::tick_cnt_t  lat_burst_o
);
  import rg_axi_pkg::*;
  import rg_guard_pkg::*;

  txn_phase_e                phase_q, phase_d;
  tick_cnt_t                 first_lat_q;
  tick_cnt_t                 cur_cnt;
  logic [$bits(axi_len_t):0] beats;
  burst_budget_t             burst_budget;
  logic beat, waiting, in_burst, first_now, complete;
  logic ar_stall_late, unwanted, first_late, burst_late;

  assign beat     = r_valid_i && r_ready_i;
  assign in_burst = (phase_q == PHASE_IN_BURST);
  // A fresh head in IDLE already waits for data, with nothing counted yet
  assign waiting  = (phase_q == PHASE_WAIT_FIRST) || ((phase_q == PHASE_IDLE) && head_valid_i);
  assign cur_cnt  = (phase_q == PHASE_IDLE) ? '0 : phase_cnt_i;

  assign first_now = waiting && r_valid_i;
  assign unwanted  = beat && (!head_valid_i || (r_id_i != head_id_i));
  assign complete  = beat && r_last_i && !unwanted && (waiting || in_burst);

  assign beats        = $bits(beats)'(head_len_i) + 1'b1;
  assign burst_budget = burst_budget_t'(budget_beat_i) * burst_budget_t'(beats);

  // Budget checks
  assign ar_stall_late = ar_valid_i && !ar_ready_i && (ar_stall_cnt_i > budget_ar_i);
  assign first_late    = waiting && (cur_cnt > budget_first_i);
  assign burst_late    = in_burst && (burst_budget_t'(phase_cnt_i) > burst_budget);

  assign err_valid_o = overflow_i || ar_stall_late || unwanted || first_late || burst_late;
  assign flush_o     = err_valid_o;
  assign pop_o       = complete && !err_valid_o;

  // One cause per cycle, highest priority first
  always_comb begin
    err_cause_o = CAUSE_NONE;
    err_addr_o  = '0;
    err_id_o    = '0;
    if (overflow_i) begin
      err_cause_o = CAUSE_OVERFLOW;
      err_addr_o  = ar_addr_i;
      err_id_o    = ar_id_i;
    end else if (ar_stall_late) begin
      err_cause_o = CAUSE_AR_STALL;
      err_addr_o  = ar_addr_i;
      err_id_o    = ar_id_i;
    end else if (unwanted) begin
      err_cause_o = CAUSE_UNWANTED;
      err_id_o    = r_id_i;
    end else if (first_late || burst_late) begin
      err_cause_o = first_late ? CAUSE_FIRST_LATE : CAUSE_BURST_LATE;
      err_addr_o  = head_addr_i;
      err_id_o    = head_id_i;
    end
  end

  always_comb begin
    phase_d = phase_q;
    if (flush_o || complete) begin
      phase_d = PHASE_IDLE;
    end else if (first_now) begin
      phase_d = PHASE_IN_BURST;
    end else if ((phase_q == PHASE_IDLE) && head_valid_i) begin
      phase_d = PHASE_WAIT_FIRST;
    end
  end

  // Phase count restarts on every phase change
  assign phase_clr_o = (phase_d != phase_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PHASE_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_now) begin
      first_lat_q <= cur_cnt;
    end
  end

  assign lat_valid_o = pop_o;
  assign lat_first_o = in_burst ? first_lat_q : cur_cnt;
  assign lat_burst_o = in_burst ? phase_cnt_i : '0;

endmodule

`default_nettype wire

// File: logic/rg_status_regs.sv
/*
 * Error record and completion report of the read guard. Keeps the first
 * error until it is cleared, and the latencies of the last completed read.
 */

`default_nettype none

module rg_status_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     reset_clear_i,
  input  logic                     err_valid_i,
  input  rg_guard_pkg::err_cause_e err_cause_i,
  input  rg_axi_pkg::axi_addr_t    err_addr_i,
  input  rg_axi_pkg::axi_id_t      err_id_i,
  input  logic                     lat_valid_i,
  input  rg_guard_pkg::tick_cnt_t  lat_first_i,
  input  rg_guard_pkg::tick_cnt_t  lat_burst_i,
  output logic                     irq_o,
  output logic                     reset_req_o,
  output rg_guard_pkg::err_cause_e err_cause_o,
  output rg_axi_pkg::axi_addr_t    err_addr_o,
  output rg_axi_pkg::axi_id_t      err_id_o,
  output logic                     lat_valid_o,
  output rg_guard_pkg::tick_cnt_t  lat_first_o,
  output rg_guard_pkg::tick_cnt_t  lat_burst_o
);
  import rg_axi_pkg::*;
  import rg_guard_pkg::*;

  logic       err_held_q;
  logic       capture;
  err_cause_e cause_q;
  axi_addr_t  addr_q;
  axi_id_t    id_q;
  logic       lat_valid_q;
  tick_cnt_t  lat_first_q;
  tick_cnt_t  lat_burst_q;

  // Only the first report after a clear is kept
  assign capture = err_valid_i && !err_held_q && !reset_clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_held_q  <= 1'b0;
      cause_q     <= CAUSE_NONE;
      lat_valid_q <= 1'b0;
    end else begin
      if (reset_clear_i) begin
        err_held_q <= 1'b0;
      end else if (capture) begin
        err_held_q <= 1'b1;
        cause_q    <= err_cause_i;
      end
      lat_valid_q <= lat_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q <= err_addr_i;
      id_q   <= err_id_i;
    end
    if (lat_valid_i) begin
      lat_first_q <= lat_first_i;
      lat_burst_q <= lat_burst_i;
    end
  end

  assign irq_o       = err_held_q;
  assign reset_req_o = err_held_q;
  assign err_cause_o = cause_q;
  assign err_addr_o  = addr_q;
  assign err_id_o    = id_q;
  assign lat_valid_o = lat_valid_q;
  assign lat_first_o = lat_first_q;
  assign lat_burst_o = lat_burst_q;

endmodule

`default_nettype wire

// File: logic/rg_read_guard.sv
/*
 * AXI read-channel guard, top level. Observes the AR and R channels, times
 * each read against the budget inputs and raises irq and reset request.
 */

`default_nettype none

module rg_read_guard #(
  parameter int unsigned MaxTxns      = rg_guard_pkg::DefMaxTxns,
  parameter int unsigned PrescalerDiv = rg_guard_pkg::DefPrescalerDiv
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Address channel
  input  logic                     ar_valid_i,
  input  logic                     ar_ready_i,
  input  rg_axi_pkg::axi_id_t      ar_id_i,
  input  rg_axi_pkg::axi_addr_t    ar_addr_i,
  input  rg_axi_pkg::axi_len_t     ar_len_i,
  // Read data channel
  input  logic                     r_valid_i,
  input  logic                     r_ready_i,
  input  rg_axi_pkg::axi_id_t      r_id_i,
  input  logic                     r_last_i,
  // Budgets in prescaler ticks
  input  rg_guard_pkg::tick_cnt_t  budget_ar_i,
  input  rg_guard_pkg::tick_cnt_t  budget_first_i,
  input  rg_guard_pkg::tick_cnt_t  budget_beat_i,
  input  logic                     reset_clear_i,
  output logic                     irq_o,
  output logic                     reset_req_o,
  output rg_guard_pkg::err_cause_e err_cause_o,
  output rg_axi_pkg::axi_addr_t    err_addr_o,
  output rg_axi_pkg::axi_id_t      err_id_o,
  output logic                     lat_valid_o,
  output rg_guard_pkg::tick_cnt_t  lat_first_o,
  output rg_guard_pkg::tick_cnt_t  lat_burst_o
);
  import rg_axi_pkg::*;
  import rg_guard_pkg::*;

  tick_cnt_t  ar_stall_cnt, phase_cnt;
  logic       phase_clr, pop, flush, overflow;
  logic       head_valid;
  axi_id_t    head_id;
  axi_addr_t  head_addr;
  axi_len_t   head_len;
  logic       err_valid, lat_valid;
  err_cause_e err_cause;
  axi_addr_t  err_addr;
  axi_id_t    err_id;
  tick_cnt_t  lat_first, lat_burst;

  rg_tick_timer #(.PrescalerDiv(PrescalerDiv)) i_tick_timer (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_i,
    .phase_clr_i    (phase_clr),
    .ar_stall_cnt_o (ar_stall_cnt),
    .phase_cnt_o    (phase_cnt)
  );

  rg_txn_queue #(.MaxTxns(MaxTxns)) i_txn_queue (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_i, .ar_id_i, .ar_addr_i, .ar_len_i,
    .pop_i        (pop),
    .flush_i      (flush),
    .head_valid_o (head_valid),
    .head_id_o    (head_id),
    .head_addr_o  (head_addr),
    .head_len_o   (head_len),
    .overflow_o   (overflow)
  );

  rg_txn_fsm i_txn_fsm (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_i, .ar_addr_i, .ar_id_i,
    .r_valid_i, .r_ready_i, .r_last_i, .r_id_i,
    .budget_ar_i, .budget_first_i, .budget_beat_i,
    .head_valid_i (head_valid), .head_id_i (head_id),
    .head_addr_i  (head_addr), .head_len_i (head_len),
    .overflow_i   (overflow), .ar_stall_cnt_i (ar_stall_cnt), .phase_cnt_i (phase_cnt),
    .pop_o        (pop), .flush_o (flush), .phase_clr_o (phase_clr),
    .err_valid_o  (err_valid), .err_cause_o (err_cause),
    .err_addr_o   (err_addr), .err_id_o (err_id),
    .lat_valid_o  (lat_valid), .lat_first_o (lat_first), .lat_burst_o (lat_burst)
  );

  rg_status_regs i_status_regs (
    .clk_i, .rst_ni, .reset_clear_i,
    .err_valid_i (err_valid), .err_cause_i (err_cause),
    .err_addr_i  (err_addr), .err_id_i (err_id),
    .lat_valid_i (lat_valid), .lat_first_i (lat_first), .lat_burst_i (lat_burst),
    .irq_o, .reset_req_o, .err_cause_o, .err_addr_o, .err_id_o,
    .lat_valid_o, .lat_first_o, .lat_burst_o
  );

endmodule

`default_nettype wire

// File: dv/rg_read_guard_properties.sv
/*
 * Concurrent checks on the interrupt, error record and latency outputs of
 * the read guard. Bound into rg_read_guard by the testbench.
 */

`default_nettype none

module rg_read_guard_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     reset_clear_i,
  input logic                     irq_i,
  input logic                     reset_req_i,
  input rg_guard_pkg::err_cause_e err_cause_i,
  input logic                     lat_valid_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import rg_guard_pkg::*;

  int unsigned fail_cnt = 0;

  // Both outputs come from the same held error
  irq_is_reset_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_i == reset_req_i)
  else begin
    $error("irq and reset request differ");
    fail_cnt++;
  end

  irq_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_i |-> (err_cause_i != CAUSE_NONE))
  else begin
    $error("irq raised with no error cause");
    fail_cnt++;
  end

  lat_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lat_valid_i |=> !lat_valid_i)
  else begin
    $error("latency valid held for more than one cycle");
    fail_cnt++;
  end

  // Only a clear in the cycle before may drop the interrupt
  irq_falls_on_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(irq_i) |-> $past(reset_clear_i))
  else begin
    $error("irq dropped without a clear");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: dv/rg_read_guard_tb.sv
/*
 * Table-driven testbench of the AXI read guard. Each row drives one scenario
 * on the AR and R channels, then checks the error record and the latencies.
 */

`default_nettype none

module rg_read_guard_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rg_axi_pkg::*;
  import rg_guard_pkg::*;

  localparam int ClkPeriod = 40;
  localparam int TickDiv   = 4;
  localparam int NumRows   = 10;

  typedef enum {K_READ, K_PIPE, K_ORPHAN, K_BAD_ID, K_OVERFLOW} kind_e;

  typedef struct {
    kind_e      kind;
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    int         stall;
    int         first_dly;
    int         gap;
    tick_cnt_t  b_ar;
    tick_cnt_t  b_first;
    tick_cnt_t  b_beat;
    err_cause_e exp_cause;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        ar_valid_i, ar_ready_i, r_valid_i, r_ready_i, r_last_i, reset_clear_i;
  axi_id_t     ar_id_i, r_id_i, err_id_o;
  axi_addr_t   ar_addr_i, err_addr_o;
  axi_len_t    ar_len_i;
  tick_cnt_t   budget_ar_i, budget_first_i, budget_beat_i, lat_first_o, lat_burst_o;
  logic        irq_o, reset_req_o, lat_valid_o;
  err_cause_e  err_cause_o;
  row_t        rows [NumRows];
  int unsigned seed = 34208;

  rg_read_guard #(.MaxTxns(4), .PrescalerDiv(TickDiv)) dut_i (.*);

  bind rg_read_guard rg_read_guard_properties props_i (
    .clk_i, .rst_ni, .reset_clear_i, .irq_i(irq_o), .reset_req_i(reset_req_o),
    .err_cause_i(err_cause_o), .lat_valid_i(lat_valid_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic int unsigned lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_on_error($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_cause(input string name, input err_cause_e got, input err_cause_e exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
  endtask

  // A measured latency may be off by one tick from cycles over the divider
  task automatic check_ticks(input string name, input tick_cnt_t got, input int cycles);
    if (int'(got) < cycles / TickDiv - 1 || int'(got) > cycles / TickDiv + 1) begin
      report_mismatch(name, 32'(got), 32'(cycles / TickDiv));
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic issue_read(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                            input int stall);
    ar_valid_i = 1'b1;
    ar_ready_i = 1'b0;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    repeat (stall) step();
    ar_ready_i = 1'b1;
    step();
    ar_valid_i = 1'b0;
  endtask

  // Only the gap after the first beat is slow, later beats are back to back
  task automatic respond(input axi_id_t id, input axi_len_t len, input int first_dly,
                         input int gap);
    repeat (first_dly) step();
    for (int b = 0; b <= int'(len); b++) begin
      r_valid_i = 1'b1;
      r_id_i    = id;
      r_last_i  = (b == int'(len));
      step();
      r_valid_i = 1'b0;
      r_last_i  = 1'b0;
      if (b == 0 && len != 0) repeat (gap) step();
    end
  endtask

  task automatic check_latency(input axi_len_t len, input int first_dly, input int gap);
    int burst_cycles;
    burst_cycles = (len == 0) ? 0 : gap + int'(len);
    while (!lat_valid_o) step();
    check_ticks("lat_first_o", lat_first_o, first_dly);
    check_ticks("lat_burst_o", lat_burst_o, burst_cycles);
  endtask

  task automatic clear_error();
    if (!reset_req_o) stop_on_error("reset request dropped before the clear");
    reset_clear_i = 1'b1;
    step();
    reset_clear_i = 1'b0;
    if (irq_o || reset_req_o) stop_on_error("interrupt still high after the clear");
  endtask

  task automatic run_row(input row_t r);
    axi_addr_t exp_addr;
    axi_id_t   exp_id;
    exp_addr       = r.addr;
    exp_id         = r.id;
    budget_ar_i    = r.b_ar;
    budget_first_i = r.b_first;
    budget_beat_i  = r.b_beat;
    case (r.kind)
      K_PIPE: begin
        for (int k = 0; k < 3; k++) begin
          issue_read(r.id + axi_id_t'(k), r.addr + axi_addr_t'(16 * k), r.len, 0);
        end
        for (int k = 0; k < 3; k++) begin
          respond(r.id + axi_id_t'(k), r.len, r.first_dly, r.gap);
          check_latency(r.len, r.first_dly, r.gap);
        end
      end
      K_ORPHAN: begin
        respond(r.id, 8'd0, r.first_dly, 0);
        exp_addr = '0;
      end
      K_BAD_ID: begin
        issue_read(r.id, r.addr, r.len, 0);
        respond(r.id ^ 4'h5, r.len, r.first_dly, r.gap);
        exp_addr = '0;
        exp_id   = r.id ^ 4'h5;
      end
      K_OVERFLOW: begin
        // Fifth read finds the queue full
        for (int k = 0; k < 5; k++) begin
          issue_read(r.id + axi_id_t'(k), r.addr + axi_addr_t'(16 * k), r.len, 0);
        end
        exp_addr = r.addr + 32'd64;
        exp_id   = r.id + 4'd4;
      end
      default: begin
        issue_read(r.id, r.addr, r.len, r.stall);
        respond(r.id, r.len, r.first_dly, r.gap);
        if (r.exp_cause inside {CAUSE_NONE, CAUSE_AR_STALL}) begin
          check_latency(r.len, r.first_dly, r.gap);
        end
      end
    endcase
    if (r.exp_cause == CAUSE_NONE) begin
      if (irq_o) stop_on_error("interrupt raised by reads within their budgets");
    end else begin
      while (!irq_o) step();
      check_cause("err_cause_o", err_cause_o, r.exp_cause);
      check_addr("err_addr_o", err_addr_o, exp_addr);
      check_id("err_id_o", err_id_o, exp_id);
      clear_error();
    end
    repeat (4) step();
  endtask

  initial begin
    rst_ni        = 1'b0;
    ar_valid_i    = 1'b0;
    ar_ready_i    = 1'b1;
    ar_id_i       = '0;
    ar_addr_i     = '0;
    ar_len_i      = '0;
    r_valid_i     = 1'b0;
    r_ready_i     = 1'b1;
    r_id_i        = '0;
    r_last_i      = 1'b0;
    reset_clear_i = 1'b0;
    budget_ar_i   = '0;
    budget_first_i = '0;
    budget_beat_i = '0;
    // kind, id, addr, len, stall, first delay, gap, budget ar/first/beat, expected cause
    rows[0] = '{K_READ,     0, 0,  3,  0,  9,  2, 100, 100, 100, CAUSE_NONE};
    rows[1] = '{K_PIPE,     0, 0,  1,  0,  6,  3, 100, 100, 100, CAUSE_NONE};
    rows[2] = '{K_READ,     0, 0,  0, 20,  5,  0,   3, 100, 100, CAUSE_AR_STALL};
    rows[3] = '{K_READ,     0, 0,  1,  0, 40,  2, 100,   2, 100, CAUSE_FIRST_LATE};
    rows[4] = '{K_READ,     0, 0,  1,  0,  2, 40, 100, 100,   2, CAUSE_BURST_LATE};
    rows[5] = '{K_READ,     0, 0, 15,  0,  2, 40, 100, 100,   2, CAUSE_NONE};
    rows[6] = '{K_ORPHAN,   0, 0,  0,  0,  2,  0, 100, 100, 100, CAUSE_UNWANTED};
    rows[7] = '{K_BAD_ID,   0, 0,  0,  0,  3,  0, 100, 100, 100, CAUSE_UNWANTED};
    rows[8] = '{K_OVERFLOW, 0, 0,  0,  0,  0,  0, 100, 100, 100, CAUSE_OVERFLOW};
    rows[9] = '{K_READ,     0, 0,  2,  0,  3,  1, 100, 100, 100, CAUSE_NONE};
    foreach (rows[i]) begin
      rows[i].id   = axi_id_t'(lcg_next() >> 16);
      rows[i].addr = lcg_next() & 32'hFFFF_FFF0;
    end
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_cause("err_cause_o", err_cause_o, CAUSE_NONE);
    if (irq_o || reset_req_o || lat_valid_o) stop_on_error("outputs not idle after reset");
    foreach (rows[i]) run_row(rows[i]);
    if (dut_i.props_i.fail_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_on_error("concurrent assertions reported failures");
    end
  end

  initial begin
    #(NumRows * 400 * ClkPeriod);
    stop_on_error("watchdog expired before all scenario rows completed");
  end

endmodule

`default_nettype wire

// File: flist.f
logic/rg_axi_pkg.sv
logic/rg_guard_pkg.sv
logic/rg_tick_timer.sv
logic/rg_txn_queue.sv
logic/rg_txn_fsm.sv
logic/rg_status_regs.sv
logic/rg_read_guard.sv
dv/rg_read_guard_properties.sv
dv/rg_read_guard_tb.sv
